//--- axis2axi_wr.f
axi_pkg.sv
axis2axi_cfg_pkg.sv
fifo_rd_if.sv
axis_buffer.sv
burst_sizer.sv
axi_write_engine.sv
axis2axi_wr.sv
tb_axis2axi_wr.sv

//--- Bender.yml
package:
  name: axis2axi_wr

sources:
  - axi_pkg.sv
  - axis2axi_cfg_pkg.sv
  - fifo_rd_if.sv
  - axis_buffer.sv
  - burst_sizer.sv
  - axi_write_engine.sv
  - axis2axi_wr.sv
  - target: test
    files:
      - tb_axis2axi_wr.sv

//--- tb_axis2axi_wr.sv
/*
 * Directed testbench for the stream to AXI write bridge with a simple AXI slave.
 * Slave ready stalls are random only in the back-pressure test.
 */

`timescale 1ns/1ps

module tb_axis2axi_wr;

   localparam int TOTAL_WORDS = 8 + 3 + 4 + 30;
   localparam int TIMEOUT_NS  = TOTAL_WORDS * 40 * 4 + 2000;

   logic        clk_i;
   logic        rst_n_i;
   logic        axis_valid_i;
   logic [31:0] axis_data_i;
   logic        axis_ready_o;
   logic        cfg_valid_i;
   logic [15:0] cfg_addr_i;
   logic        cfg_ready_o;
   logic        awvalid_o;
   logic        awready_i;
   logic [15:0] awaddr_o;
   logic [7:0]  awlen_o;
   logic        wvalid_o;
   logic        wready_i;
   logic [31:0] wdata_o;
   logic        wlast_o;
   logic        bvalid_i;

   // Slave model state
   logic [31:0] mem [int];
   int          aw_addr_q[$];
   int          aw_len_q[$];
   int          w_addr;
   int          w_beat;
   int          cur_len;
   int          beats_seen;
   int          resp_seen;
   bit          stall_en;

   axis2axi_wr dut (.*);

   always #2 clk_i = ~clk_i;

   task automatic check_value(input int actual, input int expected, input string msg);
      if (actual !== expected) begin
         $display("ERR %0t ns: %s: got %0h expected %0h", $time, msg, actual, expected);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   // AXI slave, one B pulse after each last beat
   always @(posedge clk_i) begin
      awready_i <= stall_en ? 1'($urandom % 2) : 1'b1;
      wready_i  <= stall_en ? 1'($urandom % 2) : 1'b1;
      bvalid_i  <= 1'b0;
      if (rst_n_i && bvalid_i) begin
         resp_seen = resp_seen + 1;
      end
      if (rst_n_i && awvalid_o && awready_i) begin
         check_value(awlen_o <= 3, 1, "burst longer than 4 beats");
         check_value((awaddr_o % 4096) + (awlen_o + 1) * 4 <= 4096, 1, "burst crosses page");
         aw_addr_q.push_back(awaddr_o);
         aw_len_q.push_back(awlen_o);
         w_addr  = awaddr_o;
         w_beat  = 0;
         cur_len = awlen_o;
      end
      if (rst_n_i && wvalid_o && wready_i) begin
         check_value(mem.exists(w_addr), 0, "word written twice");
         check_value(wlast_o, w_beat == cur_len, "wlast position");
         mem[w_addr] = wdata_o;
         w_addr      = w_addr + 4;
         w_beat      = w_beat + 1;
         beats_seen  = beats_seen + 1;
         if (wlast_o) begin
            bvalid_i <= 1'b1;
         end
      end
   end

   task automatic load_start_addr(input logic [15:0] addr);
      @(posedge clk_i);
      while (!cfg_ready_o) begin
         @(posedge clk_i);
      end
      cfg_valid_i <= 1'b1;
      cfg_addr_i  <= addr;
      @(posedge clk_i);
      cfg_valid_i <= 1'b0;
      mem.delete();
      aw_addr_q.delete();
      aw_len_q.delete();
      beats_seen = 0;
      resp_seen  = 0;
   endtask

   task automatic send_words(input logic [31:0] base, input int n, input bit gaps);
      for (int i = 0; i < n; i++) begin
         if (gaps && ($urandom % 3 == 0)) begin
            axis_valid_i <= 1'b0;
            repeat (1 + $urandom % 3) @(posedge clk_i);
         end
         axis_valid_i <= 1'b1;
         axis_data_i  <= base + i;
         do @(posedge clk_i); while (!axis_ready_o);
      end
      axis_valid_i <= 1'b0;
   endtask

   // Every beat accepted and every burst answered
   task automatic wait_drained(input int n);
      while (beats_seen < n || resp_seen < aw_len_q.size()) begin
         @(posedge clk_i);
      end
   endtask

   task automatic check_memory(input int start, input logic [31:0] base, input int n);
      check_value(beats_seen, n, "beat count");
      for (int i = 0; i < n; i++) begin
         check_value(mem.exists(start + 4 * i), 1, "word missing");
         check_value(mem[start + 4 * i], base + i, "word data");
      end
   endtask

   // Greedy split by BURST_MAX and by 4 KB page edges
   task automatic expect_bursts(input int start, input int n);
      int addr;
      int left;
      int len;
      int room;
      int idx;
      addr = start;
      left = n;
      idx  = 0;
      while (left > 0) begin
         room = (4096 - addr % 4096) / 4;
         len  = (left < 4) ? left : 4;
         len  = (room < len) ? room : len;
         check_value(idx < aw_addr_q.size(), 1, "burst missing");
         check_value(aw_addr_q[idx], addr, "awaddr");
         check_value(aw_len_q[idx], len - 1, "awlen");
         addr = addr + len * 4;
         left = left - len;
         idx  = idx + 1;
      end
      check_value(aw_addr_q.size(), idx, "burst count");
   endtask

   task automatic run_directed(input int start, input logic [31:0] base, input int n);
      load_start_addr(start[15:0]);
      send_words(base, n, 1'b0);
      wait_drained(n);
      check_memory(start, base, n);
      expect_bursts(start, n);
   endtask

   task automatic test_reset();
      check_value(awvalid_o, 0, "awvalid after reset");
      check_value(wvalid_o, 0, "wvalid after reset");
      check_value(axis_ready_o, 1, "axis_ready after reset");
      check_value(cfg_ready_o, 1, "cfg_ready after reset");
   endtask

   task automatic test_back_pressure();
      stall_en = 1'b1;
      load_start_addr(16'h2F00);
      send_words(32'h5000_0000, 30, 1'b1);
      wait_drained(30);
      check_memory(32'h2F00, 32'h5000_0000, 30);
      // Engine is back in IDLE one cycle after the last response
      @(posedge clk_i);
      check_value(cfg_ready_o, 1, "cfg_ready after drain");
      stall_en = 1'b0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in time");
      $display("sim failed");
      $fatal(1);
   end

   initial begin
      void'($urandom(32'ha16e));
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      axis_valid_i = 1'b0;
      axis_data_i  = '0;
      cfg_valid_i  = 1'b0;
      cfg_addr_i   = '0;
      awready_i    = 1'b0;
      wready_i     = 1'b0;
      bvalid_i     = 1'b0;
      stall_en     = 1'b0;
      beats_seen   = 0;
      resp_seen    = 0;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      test_reset();
      run_directed(32'h0100, 32'h2000_0000, 8);
      run_directed(32'h0200, 32'h3000_0000, 3);
      run_directed(32'h0FF8, 32'h4000_0000, 4);
      test_back_pressure();
      $display("sim passed");
      $finish;
   end

endmodule

//--- axis2axi_wr.sv
/*
 * Stream to AXI4 write bridge. Fixed AXI fields (ID, SIZE, BURST, WSTRB, BREADY)
 * are tied off outside. cfg_valid_i may be raised only while cfg_ready_o is high.
 */

`timescale 1ns/1ps

module axis2axi_wr
   import axi_pkg::*, axis2axi_cfg_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // Stream input
   input  logic                  axis_valid_i,
   input  logic [AXI_DATA_W-1:0] axis_data_i,
   output logic                  axis_ready_o,
   // Start address
   input  logic                  cfg_valid_i,
   input  logic [AXI_ADDR_W-1:0] cfg_addr_i,
   output logic                  cfg_ready_o,
   // AXI write channels
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output logic [AXI_ADDR_W-1:0] awaddr_o,
   output logic [AXI_LEN_W-1:0]  awlen_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   output logic [AXI_DATA_W-1:0] wdata_o,
   output logic                  wlast_o,
   input  logic                  bvalid_i
);

   fifo_rd_if rd_if ();

   logic                  buf_full;
   logic [BURST_W:0]      burst_len;
   logic                  burst_ok;
   logic [AXI_ADDR_W-1:0] cur_addr;

   assign axis_ready_o = !buf_full;

   axis_buffer u_buffer (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (axis_valid_i),
      .wr_data_i(axis_data_i),
      .full_o   (buf_full),
      .rd       (rd_if.buffer)
   );

   burst_sizer u_sizer (
      .level_i        (rd_if.level),
      .stream_active_i(axis_valid_i),
      .addr_i         (cur_addr),
      .burst_len_o    (burst_len),
      .burst_ok_o     (burst_ok)
   );

   axi_write_engine u_engine (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cfg_valid_i(cfg_valid_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_ready_o(cfg_ready_o),
      .rd         (rd_if.consumer),
      .burst_len_i(burst_len),
      .burst_ok_i (burst_ok),
      .addr_o     (cur_addr),
      .awvalid_o  (awvalid_o),
      .awready_i  (awready_i),
      .awaddr_o   (awaddr_o),
      .awlen_o    (awlen_o),
      .wvalid_o   (wvalid_o),
      .wready_i   (wready_i),
      .wdata_o    (wdata_o),
      .wlast_o    (wlast_o),
      .bvalid_i   (bvalid_i)
   );

endmodule

//--- axi_write_engine.sv
/*
 * AXI4 write master FSM. One burst in flight, BRESP is not checked.
 * The start address is only loaded while idle with an empty buffer.
 */

`timescale 1ns/1ps

module axi_write_engine
   import axi_pkg::*, axis2axi_cfg_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  cfg_valid_i,
   input  logic [AXI_ADDR_W-1:0] cfg_addr_i,
   output logic                  cfg_ready_o,
   fifo_rd_if.consumer           rd,
   input  logic [BURST_W:0]      burst_len_i,
   input  logic                  burst_ok_i,
   output logic [AXI_ADDR_W-1:0] addr_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output logic [AXI_ADDR_W-1:0] awaddr_o,
   output logic [AXI_LEN_W-1:0]  awlen_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   output logic [AXI_DATA_W-1:0] wdata_o,
   output logic                  wlast_o,
   input  logic                  bvalid_i
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      RESP
   } state_t;

   state_t                state_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [BURST_W-1:0]    awlen_q;
   logic [BURST_W-1:0]    beat_q;
   logic [BURST_W:0]      len_m1;
   logic [AXI_ADDR_W-1:0] burst_bytes;
   logic                  w_hs;
   logic                  last_beat;

   assign len_m1      = burst_len_i - 1'b1;
   assign burst_bytes = AXI_ADDR_W'((awlen_q + 1) * BYTES_PER_BEAT);
   assign w_hs        = wvalid_o && wready_i;
   assign last_beat   = (beat_q == awlen_q);

   assign awvalid_o = (state_q == ADDR);
   assign awaddr_o  = addr_q;
   assign awlen_o   = AXI_LEN_W'(awlen_q);
   assign wvalid_o  = (state_q == DATA);
   assign wdata_o   = rd.rd_data;
   assign wlast_o   = wvalid_o && last_beat;
   assign addr_o    = addr_q;

   assign cfg_ready_o = (state_q == IDLE) && rd.empty;

   // First word is pre-loaded at burst start, the rest after each non-last beat
   assign rd.rd_en = ((state_q == IDLE) && burst_ok_i) || (w_hs && !last_beat);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         addr_q  <= '0;
         awlen_q <= '0;
         beat_q  <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               beat_q <= '0;
               if (cfg_valid_i) begin
                  addr_q <= cfg_addr_i;
               end
               if (burst_ok_i) begin
                  awlen_q <= len_m1[BURST_W-1:0];
                  state_q <= ADDR;
               end
            end
            ADDR: begin
               if (awready_i) begin
                  state_q <= DATA;
               end
            end
            DATA: begin
               if (w_hs && last_beat) begin
                  addr_q  <= addr_q + burst_bytes;
                  state_q <= RESP;
               end else if (w_hs) begin
                  beat_q <= beat_q + 1'b1;
               end
            end
            RESP: begin
               if (bvalid_i) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

//--- burst_sizer.sv
/*
 * Picks the next burst length from the buffer level and the 4 KB page room.
 * Assumes a word-aligned address. Purely combinational.
 */

`timescale 1ns/1ps

module burst_sizer
   import axi_pkg::*, axis2axi_cfg_pkg::*;
(
   input  logic [BUF_LVL_W-1:0]  level_i,
   input  logic                  stream_active_i,
   input  logic [AXI_ADDR_W-1:0] addr_i,
   output logic [BURST_W:0]      burst_len_o,
   output logic                  burst_ok_o
);

   logic                  full_burst;
   logic                  flush_burst;
   logic [BURST_W:0]      level_cap;
   logic [PAGE_OFS_W:0]   page_room;
   logic [PAGE_OFS_W:0]   words_left;

   // Full burst, or a partial one once the stream has paused
   assign full_burst  = (level_i >= BUF_LVL_W'(BURST_MAX));
   assign flush_burst = (level_i != '0) && !stream_active_i;
   assign burst_ok_o  = full_burst || flush_burst;

   assign level_cap = full_burst ? (BURST_W + 1)'(BURST_MAX) : level_i[BURST_W:0];

   // Bytes and then words up to the next page edge
   assign page_room  = (PAGE_OFS_W + 1)'(PAGE_BYTES) - {1'b0, addr_i[PAGE_OFS_W-1:0]};
   assign words_left = page_room >> $clog2(BYTES_PER_BEAT);

   always_comb begin
      burst_len_o = level_cap;
      // Page room smaller than the cap also fits in the length width
      if (words_left < (PAGE_OFS_W + 1)'(level_cap)) begin
         burst_len_o = words_left[BURST_W:0];
      end
   end

endmodule

//--- axis_buffer.sv
/*
 * Synchronous FIFO of 2**BUF_AW words with registered read data.
 * Writes while full are ignored. Reads while empty are not allowed.
 */

`timescale 1ns/1ps

module axis_buffer
   import axi_pkg::*, axis2axi_cfg_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_en_i,
   input  logic [AXI_DATA_W-1:0] wr_data_i,
   output logic                  full_o,
   fifo_rd_if.buffer             rd
);

   logic [AXI_DATA_W-1:0] mem_q [2**BUF_AW];
   logic [BUF_AW-1:0]     wr_ptr_q;
   logic [BUF_AW-1:0]     rd_ptr_q;
   logic [BUF_LVL_W-1:0]  level_q;
   logic                  do_wr;
   logic                  do_rd;

   // Level reaches 2**BUF_AW only when full, so its top bit is the full flag
   assign full_o   = level_q[BUF_AW];
   assign rd.empty = (level_q == '0);
   assign rd.level = level_q;

   assign do_wr = wr_en_i && !full_o;
   assign do_rd = rd.rd_en && !rd.empty;

   // Pointers and level
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // Storage array
   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem_q[wr_ptr_q] <= wr_data_i;
      end
   end

   // Read data holds until the next read
   always_ff @(posedge clk_i) begin
      if (do_rd) begin
         rd.rd_data <= mem_q[rd_ptr_q];
      end
   end

endmodule

//--- fifo_rd_if.sv
/*
 * Read side of the stream buffer. rd_en moves the oldest word into rd_data
 * on the same edge. The consumer raises rd_en only while empty is low.
 */

`timescale 1ns/1ps

interface fifo_rd_if
   import axi_pkg::*, axis2axi_cfg_pkg::*;
();

   logic                  rd_en;
   logic [AXI_DATA_W-1:0] rd_data;
   logic                  empty;
   logic [BUF_LVL_W-1:0]  level;

   modport buffer (
      input  rd_en,
      output rd_data,
      output empty,
      output level
   );

   modport consumer (
      output rd_en,
      input  rd_data,
      input  empty,
      input  level
   );

endinterface

//--- axis2axi_cfg_pkg.sv
/*
 * Burst and buffer sizing of the stream to AXI write bridge.
 * The buffer holds two maximum bursts so the stream keeps flowing during a burst.
 */

package axis2axi_cfg_pkg;

   // Largest burst is 2**BURST_W beats
   localparam int unsigned BURST_W   = 2;
   localparam int unsigned BURST_MAX = 2 ** BURST_W;

   // Buffer depth is 2**BUF_AW words
   localparam int unsigned BUF_AW    = BURST_W + 1;

   // Level counts 0 up to the full depth, hence one extra bit
   localparam int unsigned BUF_LVL_W = BUF_AW + 1;

   // AXI bursts may not cross this page
   localparam int unsigned PAGE_BYTES = 4096;
   localparam int unsigned PAGE_OFS_W = 12;

endpackage

//--- axi_pkg.sv
/*
 * AXI4 write channel widths. Only 32-bit data with full-word beats is supported.
 * Byte addresses must be at least 13 bits wide to reach a 4 KB page edge.
 */

package axi_pkg;

   // Byte address width of AW and of the internal address register
   localparam int unsigned AXI_ADDR_W = 16;

   // Data bus width, one word per beat
   localparam int unsigned AXI_DATA_W = 32;

   // Width of the AWLEN field
   localparam int unsigned AXI_LEN_W = 8;

   // Bytes moved by one W beat
   // Must stay a power of two, the page math shifts by its log2
   localparam int unsigned BYTES_PER_BEAT = AXI_DATA_W / 8;

endpackage
